// ==== vlog.f ====
+incdir+src
src/icache_pkg.sv
src/icache_way_store.sv
src/icache_tag_lookup.sv
src/icache_refill_ctrl.sv
src/icache_word_select.sv
src/icache_top.sv
tests/tb_icache_mem.sv
tests/tb_icache.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_icache
FILELIST  = vlog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tb_icache;
    import icache_pkg::*;

    typedef enum logic [1:0] {
        OUT_HIT,
        OUT_MISS,
        OUT_ERR
    } outcome_e;

    typedef struct {
        string       name;
        logic [31:0] addr;
        outcome_e    exp;
    } row_t;

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    row_t rows[$];
    int   limit;
    int   cycles;

    // reference model of the cache state
    logic                     model_valid [0:1][0:`ICACHE_SETS-1];
    logic [`ICACHE_TAG_W-1:0] model_tag   [0:1][0:`ICACHE_SETS-1];
    logic                     model_lru   [0:`ICACHE_SETS-1];   // victim way

    icache_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    tb_icache_mem u_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    function automatic string rsp_text(input apb_rsp_t r);
        return $sformatf("pready=%0b pslverr=%0b prdata=%08h", r.pready, r.pslverr, r.prdata);
    endfunction

    function automatic string req_text(input mem_req_t r);
        return $sformatf("rd_req=%0b rd_addr=%08h", r.rd_req, r.rd_addr);
    endfunction

    task automatic check_apb_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: apb_rsp expected %s, actual %s",
                                name, rsp_text(exp), rsp_text(act)));
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: mem_req expected %s, actual %s",
                                name, req_text(exp), req_text(act)));
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERR %s: %s expected %0d, actual %0d", name, what, exp, act));
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] addr, input outcome_e exp);
        row_t r;
        r.name = name;
        r.addr = addr;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return {~a[31:16], a[15:0]};
    endfunction

    // lru bit per set names the next victim
    task automatic model_access(input logic [31:0] addr, output outcome_e res);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       victim;
        idx = addr[11:5];
        tag = addr[31:12];
        if (addr[1:0] != 2'b00) begin
            res = OUT_ERR;
        end else if (model_valid[0][idx] && model_tag[0][idx] == tag) begin
            res = OUT_HIT;
            model_lru[idx] = 1'b1;
        end else if (model_valid[1][idx] && model_tag[1][idx] == tag) begin
            res = OUT_HIT;
            model_lru[idx] = 1'b0;
        end else begin
            res    = OUT_MISS;
            victim = model_lru[idx];
            model_valid[victim][idx] = 1'b1;
            model_tag[victim][idx]   = tag;
            model_lru[idx]           = ~victim;
        end
    endtask

    task automatic run_row(input row_t r);
        apb_req_t    req;
        apb_rsp_t    exp_rsp;
        mem_req_t    exp_req;
        logic [31:0] line_addr;
        int          waits;
        int          ret_at;
        int          rises;
        logic        prev;
        logic        saw_req;
        line_addr       = {r.addr[31:5], 5'b0};
        exp_rsp.pready  = 1'b1;
        exp_rsp.pslverr = (r.exp == OUT_ERR);
        exp_rsp.prdata  = (r.exp == OUT_ERR) ? 32'h0 : expected_word(r.addr);
        exp_req.rd_req  = 1'b1;
        exp_req.rd_addr = line_addr;
        waits   = 0;
        ret_at  = -1;
        rises   = 0;
        prev    = 1'b0;
        saw_req = 1'b0;
        req.psel     = 1'b1;
        req.penable  = 1'b0;
        req.paddr.raw = r.addr;
        @(posedge clk);
        apb_req <= req;   // setup
        @(negedge clk);
        check_count(r.name, "pready in setup cycle", 0, int'(apb_rsp.pready));
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        do begin
            @(negedge clk);
            waits++;
            if (mem_req.rd_req && !prev) begin
                rises++;
            end
            prev = mem_req.rd_req;
            if (mem_req.rd_req && !saw_req) begin
                check_mem_req(r.name, exp_req, mem_req);
                saw_req = 1'b1;
            end
            if (mem_rsp.ret_valid) begin
                ret_at = waits;
            end
        end while (!apb_rsp.pready);
        check_apb_rsp(r.name, exp_rsp, apb_rsp);
        check_count(r.name, "memory requests", (r.exp == OUT_MISS) ? 1 : 0, rises);
        if (r.exp == OUT_MISS) begin
            check_count(r.name, "cycles from ret_valid to pready", 1, waits - ret_at);
        end else begin
            check_count(r.name, "access cycles", 1, waits);
            exp_req.rd_req = 1'b0;
            check_mem_req(r.name, exp_req, mem_req);
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (limit > 0 && cycles > limit) begin
                abort_run($sformatf("timeout: tests did not finish within %0d cycles", limit));
            end
        end
    end

    initial begin
        outcome_e predicted;
        apb_req = '0;
        reset   = 1'b1;
        limit   = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end

        // lines a, b, c share index 5
        add_row("a_first_miss",    32'h0000_10A4, OUT_MISS);
        add_row("a_same_line_hit", 32'h0000_10B8, OUT_HIT);
        add_row("b_first_miss",    32'h0000_20A0, OUT_MISS);
        add_row("a_alt_hit",       32'h0000_10AC, OUT_HIT);
        add_row("b_alt_hit",       32'h0000_20BC, OUT_HIT);
        add_row("a_alt_hit2",      32'h0000_10A0, OUT_HIT);
        add_row("c_evicts_b",      32'h0000_30A8, OUT_MISS);
        add_row("a_kept_hit",      32'h0000_10B0, OUT_HIT);
        add_row("b_evicted_miss",  32'h0000_20A4, OUT_MISS);
        add_row("misaligned_2",    32'h0000_10A2, OUT_ERR);
        add_row("misaligned_3",    32'h0000_5003, OUT_ERR);
        add_row("other_set_miss",  32'h1234_5670, OUT_MISS);
        add_row("other_set_hit",   32'h1234_567C, OUT_HIT);
        add_row("c_evicted_miss",  32'h0000_30A0, OUT_MISS);
        add_row("b_kept_hit",      32'h0000_20B4, OUT_HIT);
        limit = rows.size() * 14 + 10;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_apb_rsp("after_reset", '0, apb_rsp);
        check_mem_req("after_reset", '0, mem_req);

        foreach (rows[i]) begin
            model_access(rows[i].addr, predicted);
            if (predicted != rows[i].exp) begin
                abort_run($sformatf("reference model disagrees with the table at %s",
                                    rows[i].name));
            end
            run_row(rows[i]);
        end

        @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_icache_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tb_icache_mem (
    input  logic                 clk,
    input  logic                 reset,
    input  icache_pkg::mem_req_t mem_req_i,
    output icache_pkg::mem_rsp_t mem_rsp_o
);
    import icache_pkg::*;

    logic [15:0] lfsr_q;
    logic [3:0]  wait_q;
    logic        busy_q;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // each word is its byte address with the upper half inverted
    function automatic logic [`ICACHE_LINE_W-1:0] build_line(input logic [31:0] base);
        logic [`ICACHE_LINE_W-1:0] line;
        logic [31:0]               a;
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            a = base + 32'(4 * w);
            line[w*32 +: 32] = {~a[31:16], a[15:0]};
        end
        return line;
    endfunction

    initial mem_rsp_o = '0;

    always @(posedge clk) begin : serve
        logic [15:0] st;
        logic [3:0]  delay;
        if (reset) begin
            lfsr_q    <= 16'd80;
            busy_q    <= 1'b0;
            wait_q    <= '0;
            mem_rsp_o <= '0;
        end else begin
            mem_rsp_o.ret_valid <= 1'b0;   // one-cycle pulse
            if (busy_q) begin
                if (wait_q == 4'd1) begin
                    mem_rsp_o.ret_valid <= 1'b1;
                    mem_rsp_o.ret_data  <= build_line(mem_req_i.rd_addr);
                    busy_q              <= 1'b0;
                end else begin
                    wait_q <= wait_q - 4'd1;
                end
            end else if (mem_req_i.rd_req && !mem_rsp_o.ret_valid) begin
                st    = lfsr_q;
                delay = '0;
                for (int i = 0; i < 3; i++) begin
                    delay = {delay[2:0], st[0]};   // one step per bit
                    st    = lfsr_next(st);
                end
                wait_q <= delay + 4'd1;
                busy_q <= 1'b1;
                lfsr_q <= st;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  icache_pkg::apb_req_t apb_req_i,
    output icache_pkg::apb_rsp_t apb_rsp_o,
    output icache_pkg::mem_req_t mem_req_o,
    input  icache_pkg::mem_rsp_t mem_rsp_i
);
    import icache_pkg::*;

    tag_entry_t                entry0;
    tag_entry_t                entry1;
    logic [`ICACHE_LINE_W-1:0] line0;
    logic [`ICACHE_LINE_W-1:0] line1;
    lookup_t                   lookup;
    logic [`ICACHE_WAYS-1:0]   way_we;
    logic                      ready;
    logic                      slverr;
    logic                      from_refill;
    logic [`ICACHE_DATA_W-1:0] rdata;

    // index comes straight from paddr in setup and access cycles
    icache_way_store u_way0 (
        .clk      (clk),
        .reset    (reset),
        .index_i  (apb_req_i.paddr.f.index),
        .we_i     (way_we[0]),
        .wtag_i   (apb_req_i.paddr.f.tag),
        .wline_i  (mem_rsp_i.ret_data),
        .rentry_o (entry0),
        .rline_o  (line0)
    );

    icache_way_store u_way1 (
        .clk      (clk),
        .reset    (reset),
        .index_i  (apb_req_i.paddr.f.index),
        .we_i     (way_we[1]),
        .wtag_i   (apb_req_i.paddr.f.tag),
        .wline_i  (mem_rsp_i.ret_data),
        .rentry_o (entry1),
        .rline_o  (line1)
    );

    icache_tag_lookup u_tag_lookup (
        .req_i    (apb_req_i),
        .entry0_i (entry0),
        .entry1_i (entry1),
        .lookup_o (lookup)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_i         (apb_req_i),
        .lookup_i      (lookup),
        .mem_rsp_i     (mem_rsp_i),
        .mem_req_o     (mem_req_o),
        .we_o          (way_we),
        .ready_o       (ready),
        .slverr_o      (slverr),
        .from_refill_o (from_refill)
    );

    icache_word_select u_word_select (
        .clk           (clk),
        .req_i         (apb_req_i),
        .lookup_i      (lookup),
        .line0_i       (line0),
        .line1_i       (line1),
        .mem_rsp_i     (mem_rsp_i),
        .from_refill_i (from_refill),
        .slverr_i      (slverr),
        .rdata_o       (rdata)
    );

    assign apb_rsp_o = '{pready: ready, pslverr: slverr, prdata: rdata};

endmodule

`default_nettype wire

// ==== src/icache_word_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_word_select (
    input  logic                      clk,
    input  icache_pkg::apb_req_t      req_i,
    input  icache_pkg::lookup_t       lookup_i,
    input  logic [`ICACHE_LINE_W-1:0] line0_i,
    input  logic [`ICACHE_LINE_W-1:0] line1_i,
    input  icache_pkg::mem_rsp_t      mem_rsp_i,
    input  logic                      from_refill_i,
    input  logic                      slverr_i,
    output logic [`ICACHE_DATA_W-1:0] rdata_o
);

    logic [`ICACHE_LINE_W-1:0]                          refill_line_q;
    logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_DATA_W-1:0]  words;
    logic                                               have_data;

    // ram still shows the old set in the respond cycle
    always_ff @(posedge clk) begin
        if (mem_rsp_i.ret_valid) begin
            refill_line_q <= mem_rsp_i.ret_data;
        end
    end

    always_comb begin
        if (from_refill_i) begin
            words = refill_line_q;
        end else if (lookup_i.hit_way) begin
            words = line1_i;
        end else begin
            words = line0_i;
        end
    end

    assign have_data = from_refill_i || lookup_i.hit;
    assign rdata_o   = (slverr_i || !have_data) ? '0 : words[req_i.paddr.f.word];

endmodule

`default_nettype wire

// ==== src/icache_refill_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_refill_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  icache_pkg::apb_req_t     req_i,
    input  icache_pkg::lookup_t      lookup_i,
    input  icache_pkg::mem_rsp_t     mem_rsp_i,
    output icache_pkg::mem_req_t     mem_req_o,
    output logic [`ICACHE_WAYS-1:0]  we_o,
    output logic                     ready_o,
    output logic                     slverr_o,
    output logic                     from_refill_o
);

    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        RESPOND
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    logic [`ICACHE_SETS-1:0]    lru_q;     // way to evict next
    logic [`ICACHE_INDEX_W-1:0] index;
    logic                       access;
    logic                       misaligned;
    logic                       hit_now;
    logic                       miss_now;
    logic                       victim;
    logic                       fill;

    assign access     = req_i.psel && req_i.penable;
    assign misaligned = req_i.paddr.raw[1:0] != 2'b00;
    assign index      = req_i.paddr.f.index;

    // only the first access cycle sees the lookup state
    assign hit_now  = (state_q == LOOKUP) && access && !misaligned && lookup_i.hit;
    assign miss_now = (state_q == LOOKUP) && access && !misaligned && !lookup_i.hit;

    assign victim = lru_q[index];
    assign fill   = (state_q == REFILL) && mem_rsp_i.ret_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (miss_now) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp_i.ret_valid) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: state_d = LOOKUP;
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (fill) begin
            lru_q[index] <= ~victim;              // just filled, so keep it
        end else if (hit_now) begin
            lru_q[index] <= ~lookup_i.hit_way;
        end
    end

    assign we_o[0] = fill && !victim;
    assign we_o[1] = fill && victim;

    // paddr is held by the requester, so rd_addr stays put
    assign mem_req_o.rd_req  = (state_q == REFILL);
    assign mem_req_o.rd_addr = {req_i.paddr.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                                {`ICACHE_OFFSET_W{1'b0}}};

    assign ready_o       = hit_now || (state_q == RESPOND) ||
                           ((state_q == LOOKUP) && access && misaligned);
    assign slverr_o      = (state_q == LOOKUP) && access && misaligned;
    assign from_refill_o = (state_q == RESPOND);

    // request stays up with one address until memory answers
    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_o.rd_req && !mem_rsp_i.ret_valid
            |=> mem_req_o.rd_req && $stable(mem_req_o.rd_addr));

    // no response outside the access phase
    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        ready_o |-> req_i.psel && req_i.penable);

endmodule

`default_nettype wire

// ==== src/icache_tag_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup (
    input  icache_pkg::apb_req_t   req_i,
    input  icache_pkg::tag_entry_t entry0_i,
    input  icache_pkg::tag_entry_t entry1_i,
    output icache_pkg::lookup_t    lookup_o
);

    logic access;
    logic hit0;
    logic hit1;

    // ram outputs only line up with paddr in access cycles
    assign access = req_i.psel && req_i.penable;

    assign hit0 = access && entry0_i.valid && (entry0_i.tag == req_i.paddr.f.tag);
    assign hit1 = access && entry1_i.valid && (entry1_i.tag == req_i.paddr.f.tag);

    assign lookup_o.hit     = hit0 || hit1;
    assign lookup_o.hit_way = hit1;   // way 0 otherwise

    // refill only runs on a miss, so a set never holds one tag twice
    always_comb begin
        assert final (!(hit0 && hit1))
            else $error("icache_tag_lookup: tag resident in both ways");
    end

endmodule

`default_nettype wire

// ==== src/icache_way_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_way_store (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`ICACHE_INDEX_W-1:0] index_i,
    input  logic                       we_i,
    input  logic [`ICACHE_TAG_W-1:0]   wtag_i,
    input  logic [`ICACHE_LINE_W-1:0]  wline_i,
    output icache_pkg::tag_entry_t     rentry_o,
    output logic [`ICACHE_LINE_W-1:0]  rline_o
);
    import icache_pkg::*;

    logic [`ICACHE_LINE_W-1:0] data_mem [0:`ICACHE_SETS-1];
    logic [`ICACHE_TAG_W-1:0]  tag_mem  [0:`ICACHE_SETS-1];
    logic [`ICACHE_SETS-1:0]   valid_q;
    tag_entry_t                entry_q;
    logic [`ICACHE_LINE_W-1:0] line_q;

    // whole line and tag in one write
    always_ff @(posedge clk) begin
        if (we_i) begin
            data_mem[index_i] <= wline_i;
            tag_mem[index_i]  <= wtag_i;
        end
    end

    // every set starts empty
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // sync read returns old contents on a same-set write
    always_ff @(posedge clk) begin
        entry_q.valid <= valid_q[index_i];
        entry_q.tag   <= tag_mem[index_i];
        line_q        <= data_mem[index_i];
    end

    assign rentry_o = entry_q;
    assign rline_o  = line_q;

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // field view of a fetch address
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]                                  tag;
        logic [`ICACHE_INDEX_W-1:0]                                index;
        logic [$clog2(`ICACHE_LINE_WORDS)-1:0]                     word;
        logic [`ICACHE_OFFSET_W-$clog2(`ICACHE_LINE_WORDS)-1:0]    byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;  // memory requests, alignment
        fetch_fields_t             f;    // ram index and tag compare
    } fetch_addr_u;

    typedef struct packed {
        logic        psel;
        logic        penable;
        fetch_addr_u paddr;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic                      pslverr;
        logic [`ICACHE_DATA_W-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic                      rd_req;
        logic [`ICACHE_ADDR_W-1:0] rd_addr;
    } mem_req_t;

    typedef struct packed {
        logic                      ret_valid;
        logic [`ICACHE_LINE_W-1:0] ret_data;
    } mem_rsp_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic hit;
        logic hit_way;  // 0 when no hit
    } lookup_t;

endpackage

`default_nettype wire

// ==== src/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address split
`define ICACHE_ADDR_W      32
`define ICACHE_DATA_W      32
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     7
`define ICACHE_OFFSET_W    5   // byte offset within a line

// geometry
`define ICACHE_SETS        128
`define ICACHE_WAYS        2
`define ICACHE_LINE_WORDS  8
`define ICACHE_LINE_W      256 // one refill beat carries the whole line

`endif
